// ==== Makefile ====
TOP = tb_stq

.PHONY: sim clean

sim:
	verilator --binary --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== sim/tb_stq.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_stq
  import stq_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 4;
  localparam int NUM_OPS       = 45;
  localparam int OP_CYCLES     = 3;
  localparam int DRAIN_CYCLES  = 20;
  localparam int MARGIN_CYCLES = 50;
  localparam int WATCHDOG_CYCLES = 5 * RESET_CYCLES + NUM_OPS * OP_CYCLES +
                                   DRAIN_CYCLES + MARGIN_CYCLES;

  logic               i_clk;
  logic               i_reset_n;
  logic               i_alloc_valid;
  logic [PADDR_W-1:0] i_alloc_paddr;
  size_e              i_alloc_size;
  stq_ptr_t           o_alloc_idx;
  logic               o_stq_full;
  logic               i_data_valid;
  logic [IDX_W-1:0]   i_data_idx;
  logic [DATA_W-1:0]  i_data;
  logic               i_commit;
  logic               i_ld_valid;
  logic [PADDR_W-1:0] i_ld_paddr;
  size_e              i_ld_size;
  stq_ptr_t           i_ld_age;
  logic               o_fwd_valid;
  logic [7:0]         o_fwd_bytes;
  logic [DATA_W-1:0]  o_fwd_data;
  logic               o_fwd_haz;
  logic               o_stbuf_valid;
  logic [PADDR_W-1:0] o_stbuf_paddr;
  logic [7:0]         o_stbuf_strb;
  logic [DATA_W-1:0]  o_stbuf_data;
  logic               i_stbuf_full;

  integer   seed;
  int       errors;
  int       checks;
  int       tests;
  int       test_start_errs;
  stq_ptr_t exp_tail;

  logic [PADDR_W-1:0] st_paddr [STQ_SIZE];
  size_e              st_size  [STQ_SIZE];
  logic [DATA_W-1:0]  st_data  [STQ_SIZE];

  stq_top uut (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_alloc_valid (i_alloc_valid), .i_alloc_paddr (i_alloc_paddr),
    .i_alloc_size (i_alloc_size), .o_alloc_idx (o_alloc_idx), .o_stq_full (o_stq_full),
    .i_data_valid (i_data_valid), .i_data_idx (i_data_idx), .i_data (i_data),
    .i_commit (i_commit),
    .i_ld_valid (i_ld_valid), .i_ld_paddr (i_ld_paddr), .i_ld_size (i_ld_size),
    .i_ld_age (i_ld_age), .o_fwd_valid (o_fwd_valid), .o_fwd_bytes (o_fwd_bytes),
    .o_fwd_data (o_fwd_data), .o_fwd_haz (o_fwd_haz),
    .o_stbuf_valid (o_stbuf_valid), .o_stbuf_paddr (o_stbuf_paddr),
    .o_stbuf_strb (o_stbuf_strb), .o_stbuf_data (o_stbuf_data),
    .i_stbuf_full (i_stbuf_full)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ============================================================
  // expected-value helpers
  // ============================================================
  // 1, 2, 4 or 8 bytes starting at the offset
  function automatic logic [7:0] byte_enables(input size_e sz, input logic [2:0] ofs);
    int          nbytes;
    logic [15:0] ones;
    nbytes = 1 << int'(sz);
    ones   = (16'h1 << nbytes) - 16'h1;
    return ones[7:0] << ofs;
  endfunction

  function automatic logic [63:0] byte_lanes(input logic [7:0] mask);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{mask[b]}};
    end
    return m;
  endfunction

  function automatic logic [63:0] rand_dword();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // store buffer fields for the k-th store in program order
  task automatic check_stbuf_write(input int k);
    check("o_stbuf_paddr", 64'(o_stbuf_paddr), 64'({st_paddr[k][31:3], 3'b000}));
    check("o_stbuf_strb", 64'(o_stbuf_strb),
          64'(byte_enables(st_size[k], st_paddr[k][2:0])));
    check("o_stbuf_data", o_stbuf_data, st_data[k] << {st_paddr[k][2:0], 3'b000});
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - test_start_errs);
  endtask

  // ============================================================
  // drivers
  // ============================================================
  task automatic apply_reset();
    @(posedge i_clk);
    i_reset_n     <= 1'b0;
    i_alloc_valid <= 1'b0;
    i_data_valid  <= 1'b0;
    i_commit      <= 1'b0;
    i_ld_valid    <= 1'b0;
    i_stbuf_full  <= 1'b0;
    repeat (3) @(posedge i_clk);
    i_reset_n <= 1'b1;
    exp_tail = '0;
    test_start_errs = errors;
  endtask

  task automatic alloc_store(input logic [31:0] paddr, input size_e sz);
    @(negedge i_clk);
    check("o_alloc_idx", 64'(o_alloc_idx), 64'(exp_tail));
    @(posedge i_clk);
    i_alloc_valid <= 1'b1;
    i_alloc_paddr <= paddr;
    i_alloc_size  <= sz;
    @(posedge i_clk);
    i_alloc_valid <= 1'b0;
    exp_tail = exp_tail + 4'd1;
  endtask

  task automatic write_data(input logic [2:0] idx, input logic [63:0] data);
    @(posedge i_clk);
    i_data_valid <= 1'b1;
    i_data_idx   <= idx;
    i_data       <= data;
    @(posedge i_clk);
    i_data_valid <= 1'b0;
  endtask

  task automatic commit_one();
    @(posedge i_clk);
    i_commit <= 1'b1;
    @(posedge i_clk);
    i_commit <= 1'b0;
  endtask

  task automatic probe_check(input logic [31:0] paddr, input size_e sz, input stq_ptr_t age,
                             input logic [7:0] exp_bytes, input logic [63:0] exp_data,
                             input logic exp_haz);
    @(posedge i_clk);
    i_ld_valid <= 1'b1;
    i_ld_paddr <= paddr;
    i_ld_size  <= sz;
    i_ld_age   <= age;
    @(negedge i_clk);
    check("o_fwd_bytes", 64'(o_fwd_bytes), 64'(exp_bytes));
    check("o_fwd_data", o_fwd_data, exp_data);
    check("o_fwd_valid", 64'(o_fwd_valid), 64'(|exp_bytes));
    check("o_fwd_haz", 64'(o_fwd_haz), 64'(exp_haz));
    @(posedge i_clk);
    i_ld_valid <= 1'b0;
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic test_reset();
    apply_reset();
    @(negedge i_clk);
    check("o_stq_full", 64'(o_stq_full), 64'h0);
    check("o_stbuf_valid", 64'(o_stbuf_valid), 64'h0);
    check("o_fwd_valid", 64'(o_fwd_valid), 64'h0);
    check("o_fwd_haz", 64'(o_fwd_haz), 64'h0);
    check("o_alloc_idx", 64'(o_alloc_idx), 64'h0);
    finish_test("reset");
  endtask

  task automatic test_basic_fwd();
    logic [63:0] d;
    logic [7:0]  m;
    apply_reset();
    d = rand_dword();
    m = byte_enables(SIZE_W, 3'd4);
    alloc_store(32'h0000_1000, SIZE_DW);
    write_data(3'd0, d);
    probe_check(32'h0000_1004, SIZE_W, 4'd1, m, d & byte_lanes(m), 1'b0);
    // load as old as the store sees nothing
    probe_check(32'h0000_1004, SIZE_W, 4'd0, 8'h00, 64'h0, 1'b0);
    finish_test("basic_fwd");
  endtask

  task automatic test_youngest();
    logic [63:0] d1;
    logic [63:0] d2;
    logic [63:0] lanes2;
    logic [63:0] merged;
    apply_reset();
    d1 = rand_dword();
    d2 = rand_dword();
    lanes2 = byte_lanes(byte_enables(SIZE_B, 3'd3));
    merged = (d1 & ~lanes2) | ((d2 << 24) & lanes2);
    alloc_store(32'h0000_2000, SIZE_DW);
    alloc_store(32'h0000_2003, SIZE_B);
    write_data(3'd0, d1);
    write_data(3'd1, d2);
    probe_check(32'h0000_2000, SIZE_DW, 4'd0, 8'h00, 64'h0, 1'b0);
    probe_check(32'h0000_2000, SIZE_DW, 4'd1, 8'hff, d1, 1'b0);
    probe_check(32'h0000_2000, SIZE_DW, 4'd2, 8'hff, merged, 1'b0);
    finish_test("youngest");
  endtask

  task automatic test_hazard();
    logic [63:0] d;
    logic [7:0]  m;
    apply_reset();
    d = rand_dword();
    m = byte_enables(SIZE_W, 3'd0);
    alloc_store(32'h0000_3000, SIZE_DW);
    probe_check(32'h0000_3000, SIZE_W, 4'd1, 8'h00, 64'h0, 1'b1);
    write_data(3'd0, d);
    probe_check(32'h0000_3000, SIZE_W, 4'd1, m, d & byte_lanes(m), 1'b0);
    finish_test("hazard");
  endtask

  task automatic test_drain();
    int          nbytes;
    int          wait_cnt;
    logic [2:0]  ofs;
    apply_reset();
    @(posedge i_clk);
    i_stbuf_full <= 1'b1;
    // mixed sizes at aligned offsets, one per doubleword
    for (int k = 0; k < STQ_SIZE; k++) begin
      st_size[k]  = size_e'(k % 4);
      nbytes      = 1 << (k % 4);
      ofs         = 3'(((k * 3) % 8) & ~(nbytes - 1));
      st_paddr[k] = 32'h0000_4000 + 32'(k * 8) + 32'(ofs);
      st_data[k]  = rand_dword();
      alloc_store(st_paddr[k], st_size[k]);
    end
    @(negedge i_clk);
    check("o_stq_full", 64'(o_stq_full), 64'h1);
    for (int k = 0; k < STQ_SIZE; k++) begin
      write_data(3'(k), st_data[k]);
    end
    for (int k = 0; k < STQ_SIZE; k++) begin
      commit_one();
    end
    // back-pressure holds the head write steady
    repeat (4) begin
      @(negedge i_clk);
      check("o_stbuf_valid", 64'(o_stbuf_valid), 64'h1);
      check_stbuf_write(0);
    end
    @(posedge i_clk);
    i_stbuf_full <= 1'b0;
    for (int k = 0; k < STQ_SIZE; k++) begin
      wait_cnt = 0;
      @(negedge i_clk);
      while (!o_stbuf_valid && wait_cnt < 10) begin
        @(negedge i_clk);
        wait_cnt++;
      end
      if (!o_stbuf_valid) begin
        $display("ERROR: store %0d never reached the store buffer", k);
        errors++;
      end else begin
        check_stbuf_write(k);
      end
      // still full before the first drain, free right after it
      if (k < 2) begin
        check("o_stq_full", 64'(o_stq_full), 64'(k == 0));
      end
    end
    @(negedge i_clk);
    check("o_stbuf_valid", 64'(o_stbuf_valid), 64'h0);
    check("o_stq_full", 64'(o_stq_full), 64'h0);
    check("o_alloc_idx", 64'(o_alloc_idx), 64'h8);
    finish_test("drain");
  endtask

  // ============================================================
  // main sequence and watchdog
  // ============================================================
  initial begin
    i_clk         = 1'b0;
    i_reset_n     = 1'b0;
    i_alloc_valid = 1'b0;
    i_alloc_paddr = '0;
    i_alloc_size  = SIZE_B;
    i_data_valid  = 1'b0;
    i_data_idx    = '0;
    i_data        = '0;
    i_commit      = 1'b0;
    i_ld_valid    = 1'b0;
    i_ld_paddr    = '0;
    i_ld_size     = SIZE_B;
    i_ld_age      = '0;
    i_stbuf_full  = 1'b0;
    seed          = 32'hab36_8ebe;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    exp_tail      = '0;
    test_reset();
    test_basic_fwd();
    test_youngest();
    test_hazard();
    test_drain();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/stq_pkg.sv
verilog/oh_select.sv
verilog/stq_ptr.sv
verilog/stq_entry.sv
verilog/stq_fwd_check.sv
verilog/stq_drain.sv
verilog/stq_top.sv
sim/tb_stq.sv

// ==== verilog/oh_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module oh_select
  import stq_pkg::*;
#(
  parameter type T = logic [7:0]
) (
  input  wire logic [STQ_SIZE-1:0] i_oh,
  input  wire T                    i_data [STQ_SIZE],
  output T                         o_selected
);

  // and-or mux, zero when no bit is set
  logic [$bits(T)-1:0] acc;

  always_comb begin
    acc = '0;
    for (int i = 0; i < STQ_SIZE; i++) begin
      acc = acc | ({$bits(T){i_oh[i]}} & i_data[i]);
    end
  end

  assign o_selected = T'(acc);

endmodule

`default_nettype wire

// ==== verilog/stq_drain.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_drain
  import stq_pkg::*;
(
  input  wire stq_entry_t         i_entries [STQ_SIZE],
  input  wire stq_ptr_t           i_head,
  input  wire logic               i_stbuf_full,

  // store buffer write
  output logic                    o_stbuf_valid,
  output logic [PADDR_W-1:0]      o_stbuf_paddr,
  output logic [DW_BYTES-1:0]     o_stbuf_strb,
  output logic [DATA_W-1:0]       o_stbuf_data,

  // head is freed on this
  output logic                    o_drain
);

  logic [STQ_SIZE-1:0] head_oh;
  stq_entry_t          head_entry;
  logic [OFS_W-1:0]    ofs;

  assign head_oh = STQ_SIZE'(1) << i_head[IDX_W-1:0];

  oh_select #(
    .T (stq_entry_t)
  ) u_head_sel (
    .i_oh       (head_oh),
    .i_data     (i_entries),
    .o_selected (head_entry)
  );

  assign ofs = head_entry.paddr[OFS_W-1:0];

  // only committed stores leave the queue
  assign o_stbuf_valid = head_entry.valid & head_entry.committed;

  // doubleword-aligned write with byte strobes
  assign o_stbuf_paddr = {head_entry.paddr[PADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign o_stbuf_strb  = o_stbuf_valid ? size_to_mask(head_entry.size, ofs) : '0;
  assign o_stbuf_data  = head_entry.data << {ofs, 3'b000};

  // accepted whenever the buffer is not full
  assign o_drain = o_stbuf_valid & ~i_stbuf_full;

endmodule

`default_nettype wire

// ==== verilog/stq_entry.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_entry
  import stq_pkg::*;
(
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,

  // allocation in program order
  input  wire logic               i_alloc,
  input  wire logic [PADDR_W-1:0] i_alloc_paddr,
  input  wire size_e              i_alloc_size,

  // late store data
  input  wire logic               i_data_we,
  input  wire logic [DATA_W-1:0]  i_data,

  input  wire logic               i_commit,
  input  wire logic               i_free,

  output stq_entry_t              o_entry
);

  // ============================================================
  // status flags
  // ============================================================
  logic r_valid;
  logic r_data_valid;
  logic r_committed;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid      <= 1'b0;
      r_data_valid <= 1'b0;
      r_committed  <= 1'b0;
    end else begin
      if (i_free) begin
        r_valid <= 1'b0;
      end
      if (i_alloc) begin
        r_valid      <= 1'b1;
        r_data_valid <= 1'b0;
        r_committed  <= 1'b0;
      end
      if (i_data_we) begin
        r_data_valid <= 1'b1;
      end
      if (i_commit) begin
        r_committed <= 1'b1;
      end
    end
  end

  // ============================================================
  // payload
  // ============================================================
  logic [PADDR_W-1:0] r_paddr;
  size_e              r_size;
  logic [DATA_W-1:0]  r_data;

  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      r_paddr <= i_alloc_paddr;
      r_size  <= i_alloc_size;
    end
    if (i_data_we) begin
      r_data <= i_data;
    end
  end

  always_comb begin
    o_entry.valid      = r_valid;
    o_entry.paddr      = r_paddr;
    o_entry.size       = r_size;
    o_entry.data       = r_data;
    o_entry.data_valid = r_data_valid;
    o_entry.committed  = r_committed;
  end

endmodule

`default_nettype wire

// ==== verilog/stq_fwd_check.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_fwd_check
  import stq_pkg::*;
(
  input  wire stq_entry_t         i_entries [STQ_SIZE],
  input  wire stq_ptr_t           i_head,

  // load probe
  input  wire logic               i_ld_valid,
  input  wire logic [PADDR_W-1:0] i_ld_paddr,
  input  wire size_e              i_ld_size,
  input  wire stq_ptr_t           i_ld_age,

  output logic                    o_fwd_valid,
  output logic [DW_BYTES-1:0]     o_fwd_bytes,
  output logic [DATA_W-1:0]       o_fwd_data,
  output logic                    o_fwd_haz
);

  // highest set bit counted from the head, returned as one-hot
  function automatic logic [STQ_SIZE-1:0] pick_youngest(
    input logic [STQ_SIZE-1:0] vec,
    input logic [IDX_W-1:0]    base
  );
    logic [2*STQ_SIZE-1:0] dbl;
    logic [STQ_SIZE-1:0]   rot;
    logic [STQ_SIZE-1:0]   msb;
    dbl = {vec, vec} >> base;
    rot = dbl[STQ_SIZE-1:0];
    msb = '0;
    for (int i = 0; i < STQ_SIZE; i++) begin
      if (rot[i]) begin
        msb    = '0;
        msb[i] = 1'b1;
      end
    end
    dbl = {msb, msb} << base;
    return dbl[2*STQ_SIZE-1:STQ_SIZE];
  endfunction

  // ============================================================
  // per-entry age and address match
  // ============================================================
  logic [IDX_W:0]        ld_dist;
  logic [DW_BYTES-1:0]   ld_mask;
  logic [STQ_SIZE-1:0]   hit;
  logic [STQ_SIZE-1:0]   has_data;
  logic [DW_BYTES-1:0]   ent_mask [STQ_SIZE];
  logic [DATA_W-1:0]     aligned  [STQ_SIZE];

  assign ld_dist = i_ld_age - i_head;
  assign ld_mask = size_to_mask(i_ld_size, i_ld_paddr[OFS_W-1:0]);

  for (genvar s = 0; s < STQ_SIZE; s++) begin : g_ent
    logic [IDX_W-1:0] ent_dist;
    logic             older;
    logic             same_dw;

    assign ent_dist = IDX_W'(s) - i_head[IDX_W-1:0];
    assign older    = {1'b0, ent_dist} < ld_dist;
    assign same_dw  = i_entries[s].paddr[PADDR_W-1:OFS_W] == i_ld_paddr[PADDR_W-1:OFS_W];

    assign ent_mask[s] = size_to_mask(i_entries[s].size, i_entries[s].paddr[OFS_W-1:0]);
    assign hit[s]      = i_ld_valid & i_entries[s].valid & older & same_dw &
                         (|(ent_mask[s] & ld_mask));
    assign has_data[s] = i_entries[s].data_valid;

    // store data moved into its byte lanes
    assign aligned[s] = i_entries[s].data << {i_entries[s].paddr[OFS_W-1:0], 3'b000};
  end

  // ============================================================
  // per-byte youngest older store
  // ============================================================
  logic [DW_BYTES-1:0] haz_bytes;

  for (genvar b = 0; b < DW_BYTES; b++) begin : g_byte
    logic [STQ_SIZE-1:0] cand;
    logic [STQ_SIZE-1:0] sel_oh;
    logic [7:0]          lane [STQ_SIZE];
    logic [7:0]          sel_byte;
    logic                found;
    logic                ready;

    for (genvar s = 0; s < STQ_SIZE; s++) begin : g_lane
      assign cand[s] = hit[s] & ent_mask[s][b] & ld_mask[b];
      assign lane[s] = aligned[s][8*b +: 8];
    end

    assign sel_oh = pick_youngest(cand, i_head[IDX_W-1:0]);
    assign found  = |cand;
    assign ready  = |(sel_oh & has_data);

    oh_select #(
      .T (logic [7:0])
    ) u_byte_sel (
      .i_oh       (sel_oh),
      .i_data     (lane),
      .o_selected (sel_byte)
    );

    assign o_fwd_bytes[b]       = found & ready;
    assign haz_bytes[b]         = found & ~ready;
    assign o_fwd_data[8*b +: 8] = o_fwd_bytes[b] ? sel_byte : 8'h00;
  end

  assign o_fwd_valid = |o_fwd_bytes;
  assign o_fwd_haz   = |haz_bytes;

endmodule

`default_nettype wire

// ==== verilog/stq_pkg.sv ====
`default_nettype none

package stq_pkg;

  // queue geometry
  localparam int STQ_SIZE = 8;
  localparam int IDX_W    = 3;

  // datapath widths
  localparam int PADDR_W  = 32;
  localparam int DATA_W   = 64;
  localparam int DW_BYTES = 8;
  localparam int OFS_W    = 3;

  // index plus wrap bit, so full and empty differ
  typedef logic [IDX_W:0] stq_ptr_t;

  typedef enum logic [1:0] {
    SIZE_B  = 2'b00,
    SIZE_H  = 2'b01,
    SIZE_W  = 2'b10,
    SIZE_DW = 2'b11
  } size_e;

  typedef struct packed {
    logic               valid;
    logic [PADDR_W-1:0] paddr;
    size_e              size;
    logic [DATA_W-1:0]  data;
    logic               data_valid;
    logic               committed;
  } stq_entry_t;

  // byte enables of an aligned access within its doubleword
  function automatic logic [DW_BYTES-1:0] size_to_mask(input size_e size,
                                                       input logic [OFS_W-1:0] ofs);
    logic [DW_BYTES-1:0] base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      SIZE_DW: base = 8'hff;
      default: base = 8'h00;
    endcase
    return base << ofs;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/stq_ptr.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_ptr
  import stq_pkg::*;
(
  input  wire logic i_clk,
  input  wire logic i_reset_n,
  input  wire logic i_alloc,
  input  wire logic i_commit,
  input  wire logic i_drain,
  output stq_ptr_t  o_head,
  output stq_ptr_t  o_cmt,
  output stq_ptr_t  o_tail,
  output logic      o_full,
  output logic      o_empty
);

  stq_ptr_t r_head;
  stq_ptr_t r_cmt;
  stq_ptr_t r_tail;
  logic     alloc_ok;
  logic     commit_ok;

  // requests that would overrun are dropped here
  assign alloc_ok  = i_alloc & ~o_full;
  assign commit_ok = i_commit & (r_cmt != r_tail);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_cmt  <= '0;
      r_tail <= '0;
    end else begin
      if (alloc_ok) begin
        r_tail <= r_tail + 1'b1;
      end
      if (commit_ok) begin
        r_cmt <= r_cmt + 1'b1;
      end
      // drain only happens on a committed head
      if (i_drain) begin
        r_head <= r_head + 1'b1;
      end
    end
  end

  assign o_head = r_head;
  assign o_cmt  = r_cmt;
  assign o_tail = r_tail;

  // same index, wrap bits differ -> full
  assign o_empty = (r_head == r_tail);
  assign o_full  = (r_head[IDX_W-1:0] == r_tail[IDX_W-1:0]) &
                   (r_head[IDX_W] != r_tail[IDX_W]);

endmodule

`default_nettype wire

// ==== verilog/stq_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module stq_top
  import stq_pkg::*;
(
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,

  // allocation
  input  wire logic               i_alloc_valid,
  input  wire logic [PADDR_W-1:0] i_alloc_paddr,
  input  wire size_e              i_alloc_size,
  output stq_ptr_t                o_alloc_idx,
  output logic                    o_stq_full,

  // store data by index
  input  wire logic               i_data_valid,
  input  wire logic [IDX_W-1:0]   i_data_idx,
  input  wire logic [DATA_W-1:0]  i_data,

  input  wire logic               i_commit,

  // load probe
  input  wire logic               i_ld_valid,
  input  wire logic [PADDR_W-1:0] i_ld_paddr,
  input  wire size_e              i_ld_size,
  input  wire stq_ptr_t           i_ld_age,
  output logic                    o_fwd_valid,
  output logic [DW_BYTES-1:0]     o_fwd_bytes,
  output logic [DATA_W-1:0]       o_fwd_data,
  output logic                    o_fwd_haz,

  // store buffer
  output logic                    o_stbuf_valid,
  output logic [PADDR_W-1:0]      o_stbuf_paddr,
  output logic [DW_BYTES-1:0]     o_stbuf_strb,
  output logic [DATA_W-1:0]       o_stbuf_data,
  input  wire logic               i_stbuf_full
);

  stq_ptr_t   w_head;
  stq_ptr_t   w_cmt;
  stq_ptr_t   w_tail;
  logic       w_full;
  logic       w_empty;
  logic       w_drain;
  stq_entry_t w_entries [STQ_SIZE];

  stq_ptr u_ptr (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_alloc   (i_alloc_valid),
    .i_commit  (i_commit),
    .i_drain   (w_drain),
    .o_head    (w_head),
    .o_cmt     (w_cmt),
    .o_tail    (w_tail),
    .o_full    (w_full),
    .o_empty   (w_empty)
  );

  assign o_alloc_idx = w_tail;
  assign o_stq_full  = w_full;

  // ============================================================
  // slots and their strobes
  // ============================================================
  logic w_alloc_ok;
  logic w_commit_ok;

  assign w_alloc_ok  = i_alloc_valid & ~w_full;
  assign w_commit_ok = i_commit & (w_cmt != w_tail);

  for (genvar s = 0; s < STQ_SIZE; s++) begin : g_slot
    stq_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_alloc       (w_alloc_ok & (w_tail[IDX_W-1:0] == IDX_W'(s))),
      .i_alloc_paddr (i_alloc_paddr),
      .i_alloc_size  (i_alloc_size),
      .i_data_we     (i_data_valid & (i_data_idx == IDX_W'(s))),
      .i_data        (i_data),
      .i_commit      (w_commit_ok & (w_cmt[IDX_W-1:0] == IDX_W'(s))),
      .i_free        (w_drain & (w_head[IDX_W-1:0] == IDX_W'(s))),
      .o_entry       (w_entries[s])
    );
  end

  // empty queue has nothing to forward
  stq_fwd_check u_fwd (
    .i_entries   (w_entries),
    .i_head      (w_head),
    .i_ld_valid  (i_ld_valid & ~w_empty),
    .i_ld_paddr  (i_ld_paddr),
    .i_ld_size   (i_ld_size),
    .i_ld_age    (i_ld_age),
    .o_fwd_valid (o_fwd_valid),
    .o_fwd_bytes (o_fwd_bytes),
    .o_fwd_data  (o_fwd_data),
    .o_fwd_haz   (o_fwd_haz)
  );

  stq_drain u_drain (
    .i_entries     (w_entries),
    .i_head        (w_head),
    .i_stbuf_full  (i_stbuf_full),
    .o_stbuf_valid (o_stbuf_valid),
    .o_stbuf_paddr (o_stbuf_paddr),
    .o_stbuf_strb  (o_stbuf_strb),
    .o_stbuf_data  (o_stbuf_data),
    .o_drain       (w_drain)
  );

endmodule

`default_nettype wire
